// File: hdl/ahb_mtx_macros.svh
// AHB bus matrix output stage widths
// Address and data widths, input port count and port index width

`ifndef AHB_MTX_MACROS_SVH
`define AHB_MTX_MACROS_SVH

// ----------------------------------------------------------
// Bus widths
// ----------------------------------------------------------
`define AHB_ADDR_W 32 // HADDR width
`define AHB_DATA_W 32 // HWDATA width

// ----------------------------------------------------------
// Input ports
// ----------------------------------------------------------
`define AHB_NUM_PORTS 4 // Bus-switch inputs sharing the slave
`define AHB_PORT_W    2 // Bits to index one port

`endif

// File: hdl/ahb_mtx_pkg.sv
// AHB bus matrix output stage types
// Bus field typedefs and the HTRANS encoding

`default_nettype none

`include "ahb_mtx_macros.svh"

package ahb_mtx_pkg;

  typedef logic [`AHB_ADDR_W-1:0] haddr_t;    // Transfer address
  typedef logic [`AHB_DATA_W-1:0] hdata_t;    // Write data word
  typedef logic [2:0]             hsize_t;    // HSIZE
  typedef logic [2:0]             hburst_t;   // HBURST
  typedef logic [`AHB_PORT_W-1:0] port_idx_t; // Input port number, 0 based

  // HTRANS encoding, bit 1 marks an active transfer
  typedef enum logic [1:0] {
    HTRANS_IDLE   = 2'b00,
    HTRANS_BUSY   = 2'b01,
    HTRANS_NONSEQ = 2'b10,
    HTRANS_SEQ    = 2'b11
  } htrans_t;

endpackage

`default_nettype wire

// File: hdl/ahb_out_arbiter.sv
// AHB output stage arbiter
// Registered round-robin choice among requesting ports, grant held
// through a locked sequence even while the master deselects the slave

`timescale 1ns/1ps
`default_nettype none

`include "ahb_mtx_macros.svh"

module ahb_out_arbiter
  import ahb_mtx_pkg::*;
(
  input  wire       HCLK,                        // AHB clock
  input  wire       HRESETn,                     // Sync reset, active low
  input  wire logic i_req [`AHB_NUM_PORTS],      // Held transfer and select
  input  wire logic i_hsel_m,                    // Muxed HSEL
  input  htrans_t   i_htrans_m,                  // Muxed HTRANS
  input  wire logic i_hmastlock_m,               // Muxed HMASTLOCK
  input  wire logic i_hready,                    // Cycle accepted
  output port_idx_t o_grant_idx,                 // Granted port
  output logic      o_no_port                    // Nothing granted
);

  // ----------------------------------------------------------
  // Signals
  // ----------------------------------------------------------
  port_idx_t grant_idx_q;   // Current grant, doubles as RR pointer
  logic      no_port_q;     // No port owns the slave
  logic      hsel_lock_q;   // Locked sequence started on this slave
  logic      hsel_lock_nxt; // Next lock tracking state
  logic      lock_arb;      // Lock as seen by arbitration
  logic      xfer_active;   // NONSEQ or SEQ on the slave
  port_idx_t rr_idx;        // Round-robin winner
  logic      rr_none;       // No request found

  // ----------------------------------------------------------
  // Locked sequence tracking
  // ----------------------------------------------------------
  assign xfer_active = (i_htrans_m == HTRANS_NONSEQ) || (i_htrans_m == HTRANS_SEQ);

  // Set on a selected locked transfer, drop when lock ends
  always_comb
  begin
    hsel_lock_nxt = hsel_lock_q;
    if (i_hsel_m && xfer_active && i_hmastlock_m)
      hsel_lock_nxt = 1'b1;
    else if (!i_hmastlock_m)
      hsel_lock_nxt = 1'b0;
  end

  // Master may address elsewhere mid-sequence and still keep us
  assign lock_arb = i_hmastlock_m & (hsel_lock_q | i_hsel_m);

  // ----------------------------------------------------------
  // Round-robin search
  // ----------------------------------------------------------
  // Start one past the last grant, wrap through all ports
  always_comb
  begin
    rr_idx  = grant_idx_q; // Pointer kept when idle
    rr_none = 1'b1;
    for (int k = 1; k <= `AHB_NUM_PORTS; k++)
    begin
      if (rr_none && i_req[port_idx_t'(grant_idx_q + k)])
      begin
        rr_idx  = port_idx_t'(grant_idx_q + k);
        rr_none = 1'b0;
      end
    end
  end

  // ----------------------------------------------------------
  // Grant registers
  // ----------------------------------------------------------
  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
    begin
      grant_idx_q <= port_idx_t'(`AHB_NUM_PORTS - 1); // Port 0 first
      no_port_q   <= 1'b1;
      hsel_lock_q <= 1'b0;
    end
    else if (i_hready)
    begin
      hsel_lock_q <= hsel_lock_nxt;
      if (!lock_arb) // Locked owner keeps the slave
      begin
        grant_idx_q <= rr_idx;
        no_port_q   <= rr_none;
      end
    end
  end

  assign o_grant_idx = grant_idx_q;
  assign o_no_port   = no_port_q;

endmodule

`default_nettype wire

// File: hdl/ahb_addr_mux.sv
// AHB output stage address mux
// Routes the granted port's address and control to the slave and
// decodes the one-hot active flags back to the ports

`timescale 1ns/1ps
`default_nettype none

`include "ahb_mtx_macros.svh"

module ahb_addr_mux
  import ahb_mtx_pkg::*;
(
  input  port_idx_t i_grant_idx,                  // Granted port
  input  wire logic i_no_port,                    // Nothing granted
  input  wire logic i_sel       [`AHB_NUM_PORTS], // Per-port HSEL
  input  haddr_t    i_haddr     [`AHB_NUM_PORTS], // Per-port HADDR
  input  htrans_t   i_htrans    [`AHB_NUM_PORTS], // Per-port HTRANS
  input  wire logic i_hwrite    [`AHB_NUM_PORTS], // Per-port HWRITE
  input  hsize_t    i_hsize     [`AHB_NUM_PORTS], // Per-port HSIZE
  input  hburst_t   i_hburst    [`AHB_NUM_PORTS], // Per-port HBURST
  input  wire logic i_hmastlock [`AHB_NUM_PORTS], // Per-port HMASTLOCK
  output logic      o_active    [`AHB_NUM_PORTS], // Port owns the slave
  output logic      o_hsel_m,                     // Slave select
  output haddr_t    o_haddr_m,                    // Slave address
  output htrans_t   o_htrans_m,                   // Slave transfer type
  output logic      o_hwrite_m,                   // Slave direction
  output hsize_t    o_hsize_m,                    // Slave size
  output hburst_t   o_hburst_m,                   // Slave burst
  output logic      o_hmastlock_m                 // Slave lock
);

  // ----------------------------------------------------------
  // Active flag decode
  // ----------------------------------------------------------
  always_comb
  begin
    for (int p = 0; p < `AHB_NUM_PORTS; p++)
    begin
      o_active[p] = !i_no_port && (i_grant_idx == port_idx_t'(p)); // One-hot or zero
    end
  end

  // ----------------------------------------------------------
  // Address and control mux
  // ----------------------------------------------------------
  always_comb
  begin
    // Idle bus when nobody is granted
    o_hsel_m      = 1'b0;
    o_haddr_m     = '0;
    o_htrans_m    = HTRANS_IDLE;
    o_hwrite_m    = 1'b0;
    o_hsize_m     = '0;
    o_hburst_m    = '0;
    o_hmastlock_m = 1'b0;

    if (!i_no_port)
    begin
      o_hsel_m      = i_sel[i_grant_idx];       // Owner may look elsewhere
      o_haddr_m     = i_haddr[i_grant_idx];
      o_htrans_m    = i_htrans[i_grant_idx];
      o_hwrite_m    = i_hwrite[i_grant_idx];
      o_hsize_m     = i_hsize[i_grant_idx];
      o_hburst_m    = i_hburst[i_grant_idx];
      o_hmastlock_m = i_hmastlock[i_grant_idx]; // Feeds lock tracking
    end
  end

endmodule

`default_nettype wire

// File: hdl/ahb_data_phase.sv
// AHB output stage data phase
// Tracks which port owns the data phase, steers its write data to
// the slave and builds the shared ready

`timescale 1ns/1ps
`default_nettype none

`include "ahb_mtx_macros.svh"

module ahb_data_phase
  import ahb_mtx_pkg::*;
(
  input  wire       HCLK,                       // AHB clock
  input  wire       HRESETn,                    // Sync reset, active low
  input  port_idx_t i_grant_idx,                // Address phase owner
  input  wire logic i_hsel_m,                   // Muxed HSEL
  input  hdata_t    i_hwdata [`AHB_NUM_PORTS],  // Per-port HWDATA
  input  wire logic i_hreadyout_m,              // Slave ready
  output hdata_t    o_hwdata_m,                 // Slave write data
  output logic      o_hready                    // Shared ready
);

  // ----------------------------------------------------------
  // Data phase registers
  // ----------------------------------------------------------
  port_idx_t data_idx_q;  // Data phase owner
  logic      slave_sel_q; // Slave selected in last address phase

  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
    begin
      data_idx_q  <= '0;
      slave_sel_q <= 1'b0;
    end
    else if (o_hready) // Advance only on accepted cycles
    begin
      data_idx_q  <= i_grant_idx;
      slave_sel_q <= i_hsel_m;
    end
  end

  // ----------------------------------------------------------
  // Write data and ready
  // ----------------------------------------------------------
  assign o_hwdata_m = i_hwdata[data_idx_q]; // One phase behind address

  // Slave only stalls the bus when it owns the data phase
  assign o_hready = slave_sel_q ? i_hreadyout_m : 1'b1;

endmodule

`default_nettype wire

// File: hdl/ahb_out_stage.sv
// AHB bus matrix output stage
// Arbitrates four bus-switch inputs onto one shared slave and routes
// address, control and write data from the owning port

`timescale 1ns/1ps
`default_nettype none

`include "ahb_mtx_macros.svh"

module ahb_out_stage
  import ahb_mtx_pkg::*;
(
  input  wire       HCLK,                         // AHB clock
  input  wire       HRESETn,                      // Sync reset, active low
  input  wire logic i_sel       [`AHB_NUM_PORTS], // Per-port HSEL
  input  wire logic i_held_tran [`AHB_NUM_PORTS], // Per-port held transfer
  input  haddr_t    i_haddr     [`AHB_NUM_PORTS], // Per-port HADDR
  input  htrans_t   i_htrans    [`AHB_NUM_PORTS], // Per-port HTRANS
  input  wire logic i_hwrite    [`AHB_NUM_PORTS], // Per-port HWRITE
  input  hsize_t    i_hsize     [`AHB_NUM_PORTS], // Per-port HSIZE
  input  hburst_t   i_hburst    [`AHB_NUM_PORTS], // Per-port HBURST
  input  wire logic i_hmastlock [`AHB_NUM_PORTS], // Per-port HMASTLOCK
  input  hdata_t    i_hwdata    [`AHB_NUM_PORTS], // Per-port HWDATA
  input  wire logic i_hreadyout_m,                // Slave ready
  output logic      o_active    [`AHB_NUM_PORTS], // Port owns the slave
  output logic      o_hsel_m,                     // Slave select
  output haddr_t    o_haddr_m,                    // Slave address
  output htrans_t   o_htrans_m,                   // Slave transfer type
  output logic      o_hwrite_m,                   // Slave direction
  output hsize_t    o_hsize_m,                    // Slave size
  output hburst_t   o_hburst_m,                   // Slave burst
  output logic      o_hmastlock_m,                // Slave lock
  output hdata_t    o_hwdata_m,                   // Slave write data
  output logic      o_hreadymux_m                 // Shared ready
);

  // ----------------------------------------------------------
  // Port requests
  // ----------------------------------------------------------
  logic      req [`AHB_NUM_PORTS]; // Port wants this slave
  port_idx_t grant_idx;            // Address phase owner
  logic      no_port;              // Nothing granted

  for (genvar p = 0; p < `AHB_NUM_PORTS; p++)
  begin : g_req
    assign req[p] = i_held_tran[p] & i_sel[p];
  end

  // ----------------------------------------------------------
  // Blocks
  // ----------------------------------------------------------
  ahb_out_arbiter u_arbiter (
    .HCLK          (HCLK),
    .HRESETn       (HRESETn),
    .i_req         (req),
    .i_hsel_m      (o_hsel_m),      // Muxed control fed back
    .i_htrans_m    (o_htrans_m),
    .i_hmastlock_m (o_hmastlock_m),
    .i_hready      (o_hreadymux_m),
    .o_grant_idx   (grant_idx),
    .o_no_port     (no_port)
  );

  ahb_addr_mux u_addr_mux (
    .i_grant_idx   (grant_idx),
    .i_no_port     (no_port),
    .i_sel         (i_sel),
    .i_haddr       (i_haddr),
    .i_htrans      (i_htrans),
    .i_hwrite      (i_hwrite),
    .i_hsize       (i_hsize),
    .i_hburst      (i_hburst),
    .i_hmastlock   (i_hmastlock),
    .o_active      (o_active),
    .o_hsel_m      (o_hsel_m),
    .o_haddr_m     (o_haddr_m),
    .o_htrans_m    (o_htrans_m),
    .o_hwrite_m    (o_hwrite_m),
    .o_hsize_m     (o_hsize_m),
    .o_hburst_m    (o_hburst_m),
    .o_hmastlock_m (o_hmastlock_m)
  );

  ahb_data_phase u_data_phase (
    .HCLK          (HCLK),
    .HRESETn       (HRESETn),
    .i_grant_idx   (grant_idx),
    .i_hsel_m      (o_hsel_m),
    .i_hwdata      (i_hwdata),
    .i_hreadyout_m (i_hreadyout_m),
    .o_hwdata_m    (o_hwdata_m),
    .o_hready      (o_hreadymux_m)  // Also paces the arbiter
  );

endmodule

`default_nettype wire

// File: sim/ahb_out_stage_checker.sv
// AHB output stage protocol checks
// Concurrent assertions on the slave side, bound into the top level

`timescale 1ns/1ps
`default_nettype none

`include "ahb_mtx_macros.svh"

module ahb_out_stage_checker
  import ahb_mtx_pkg::*;
(
  input  wire       HCLK,                      // AHB clock
  input  wire       HRESETn,                   // Sync reset, active low
  input  wire logic i_active [`AHB_NUM_PORTS], // Port owns the slave
  input  wire logic i_hsel_m,                  // Slave select
  input  haddr_t    i_haddr_m,                 // Slave address
  input  htrans_t   i_htrans_m,                // Slave transfer type
  input  hdata_t    i_hwdata_m,                // Slave write data
  input  wire logic i_hreadymux_m              // Shared ready
);

  logic [`AHB_NUM_PORTS-1:0] active_vec; // Flags packed for $onehot0
  int unsigned               fail_count = 0; // Read by the testbench

  always_comb
  begin
    for (int p = 0; p < `AHB_NUM_PORTS; p++)
      active_vec[p] = i_active[p];
  end

  // ----------------------------------------------------------
  // Ownership
  // ----------------------------------------------------------
  a_active_onehot: assert property (@(posedge HCLK) disable iff (!HRESETn)
    $onehot0(active_vec))
  else
  begin
    fail_count++;
    $error("more than one port owns the slave");
  end

  a_idle_no_sel: assert property (@(posedge HCLK) disable iff (!HRESETn)
    (active_vec == '0) |-> !i_hsel_m)
  else
  begin
    fail_count++;
    $error("slave selected with no port active");
  end

  // ----------------------------------------------------------
  // Ready and stall
  // ----------------------------------------------------------
  // Unselected address phase never stalls the next cycle
  a_ready_unsel: assert property (@(posedge HCLK) disable iff (!HRESETn)
    (i_hreadymux_m && !i_hsel_m) |=> i_hreadymux_m)
  else
  begin
    fail_count++;
    $error("ready low after an unselected accepted cycle");
  end

  a_stall_stable: assert property (@(posedge HCLK) disable iff (!HRESETn)
    !i_hreadymux_m |=> ($stable(active_vec) && $stable(i_hsel_m) &&
                        $stable(i_haddr_m) && $stable(i_htrans_m) &&
                        $stable(i_hwdata_m)))
  else
  begin
    fail_count++;
    $error("slave outputs changed during a stall");
  end

endmodule

`default_nettype wire

// File: sim/tb_ahb_out_stage.sv
// Testbench for the AHB bus matrix output stage
// Directed tests of reset, arbitration, locking, data phase and stall

`timescale 1ns/1ps
`default_nettype none

`include "ahb_mtx_macros.svh"

module tb_ahb_out_stage
  import ahb_mtx_pkg::*;
();

  localparam int MAX_CYCLES = 2000; // Directed tests need under 100

  // ----------------------------------------------------------
  // DUT signals
  // ----------------------------------------------------------
  logic      HCLK;
  logic      HRESETn;
  logic      i_sel       [`AHB_NUM_PORTS];
  logic      i_held_tran [`AHB_NUM_PORTS];
  haddr_t    i_haddr     [`AHB_NUM_PORTS];
  htrans_t   i_htrans    [`AHB_NUM_PORTS];
  logic      i_hwrite    [`AHB_NUM_PORTS];
  hsize_t    i_hsize     [`AHB_NUM_PORTS];
  hburst_t   i_hburst    [`AHB_NUM_PORTS];
  logic      i_hmastlock [`AHB_NUM_PORTS];
  hdata_t    i_hwdata    [`AHB_NUM_PORTS];
  logic      i_hreadyout_m;
  logic      o_active    [`AHB_NUM_PORTS];
  logic      o_hsel_m;
  haddr_t    o_haddr_m;
  htrans_t   o_htrans_m;
  logic      o_hwrite_m;
  hsize_t    o_hsize_m;
  hburst_t   o_hburst_m;
  logic      o_hmastlock_m;
  hdata_t    o_hwdata_m;
  logic      o_hreadymux_m;

  integer      seed;              // $random state
  int          errors       = 0;  // Mismatches over all tests
  int          test_errors  = 0;
  int          tests_run    = 0;
  int          tests_failed = 0;
  int          cycles       = 0;
  int          last_grant;        // Expected round-robin pointer
  int unsigned assert_fails;
  string       test_name;

  ahb_out_stage UUT (.*);

  bind ahb_out_stage ahb_out_stage_checker u_checker (
    .HCLK          (HCLK),
    .HRESETn       (HRESETn),
    .i_active      (o_active),
    .i_hsel_m      (o_hsel_m),
    .i_haddr_m     (o_haddr_m),
    .i_htrans_m    (o_htrans_m),
    .i_hwdata_m    (o_hwdata_m),
    .i_hreadymux_m (o_hreadymux_m)
  );

  initial
  begin
    HCLK = 1'b0;
    forever #4 HCLK = ~HCLK; // 8 ns period
  end

  // Run limit
  always @(posedge HCLK)
  begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES)
    begin
      $display("Timeout after %0d cycles, tests did not finish", cycles);
      $display("Verification failed");
      $finish;
    end
  end

  // ----------------------------------------------------------
  // Helpers
  // ----------------------------------------------------------
  function automatic logic [`AHB_NUM_PORTS-1:0] active_vec();
    logic [`AHB_NUM_PORTS-1:0] v;
    for (int p = 0; p < `AHB_NUM_PORTS; p++)
      v[p] = o_active[p];
    return v;
  endfunction

  task automatic check_value(input string what, input logic [31:0] exp,
                             input logic [31:0] act);
    assert (exp === act)
    else
    begin
      $display("FAILED %s %s: expected %h, actual %h", test_name, what, exp, act);
      test_errors++;
    end
  endtask

  task automatic start_test(input string name);
    test_name   = name;
    test_errors = 0;
  endtask

  task automatic finish_test();
    tests_run++;
    if (test_errors == 0)
      $display("test %s: ok", test_name);
    else
    begin
      $display("test %s: %0d mismatches", test_name, test_errors);
      tests_failed++;
      errors += test_errors;
    end
  endtask

  // Request plus transfer type and lock for one port
  task automatic drive_port(input int p, input logic req, input htrans_t trans,
                            input logic lock);
    i_sel[p]       = req;
    i_held_tran[p] = req;
    i_htrans[p]    = trans;
    i_hmastlock[p] = lock;
  endtask

  task automatic load_port(input int p);
    i_haddr[p]  = $random(seed);
    i_hwdata[p] = $random(seed);
    i_hwrite[p] = (p % 2 == 0);
    i_hsize[p]  = hsize_t'(p);
    i_hburst[p] = hburst_t'(p + 1);
  endtask

  task automatic expect_idle_bus();
    check_value("active", 32'(active_vec()), 32'h0);
    check_value("hsel", 32'(o_hsel_m), 32'h0);
    check_value("htrans", 32'(o_htrans_m), 32'(HTRANS_IDLE));
    check_value("hready", 32'(o_hreadymux_m), 32'h1);
  endtask

  // Next negedge with the shared ready high
  task automatic wait_ready();
    @(negedge HCLK);
    while (o_hreadymux_m !== 1'b1)
      @(negedge HCLK);
  endtask

  // ----------------------------------------------------------
  // Tests
  // ----------------------------------------------------------
  initial
  begin
    seed          = 94644;
    HRESETn       = 1'b0;
    i_hreadyout_m = 1'b1;
    for (int p = 0; p < `AHB_NUM_PORTS; p++)
    begin
      drive_port(p, 1'b0, HTRANS_IDLE, 1'b0);
      load_port(p);
    end
    last_grant = `AHB_NUM_PORTS - 1; // Port 0 first after reset

    start_test("reset");
    repeat (8)
    begin
      @(negedge HCLK);
      expect_idle_bus();
    end
    HRESETn = 1'b1;
    @(negedge HCLK);
    expect_idle_bus();
    finish_test();

    start_test("single");
    drive_port(2, 1'b1, HTRANS_NONSEQ, 1'b0);
    @(negedge HCLK);
    check_value("active", 32'(active_vec()), 32'h4);
    check_value("hsel", 32'(o_hsel_m), 32'h1);
    check_value("haddr", o_haddr_m, i_haddr[2]);
    check_value("htrans", 32'(o_htrans_m), 32'(i_htrans[2]));
    check_value("hwrite", 32'(o_hwrite_m), 32'(i_hwrite[2]));
    check_value("hsize", 32'(o_hsize_m), 32'(i_hsize[2]));
    check_value("hburst", 32'(o_hburst_m), 32'(i_hburst[2]));
    last_grant = 2;
    finish_test();

    start_test("round_robin");
    for (int p = 0; p < `AHB_NUM_PORTS; p++)
      drive_port(p, 1'b1, HTRANS_NONSEQ, 1'b0); // Everyone asks, no lock
    for (int n = 0; n < 5; n++)
    begin
      @(negedge HCLK);
      last_grant = (last_grant + 1) % `AHB_NUM_PORTS;
      check_value("grant", 32'(active_vec()), 32'(1 << last_grant));
    end
    finish_test();

    start_test("locked");
    for (int p = 0; p < `AHB_NUM_PORTS; p++)
      drive_port(p, 1'b0, HTRANS_IDLE, 1'b0);
    drive_port(1, 1'b1, HTRANS_NONSEQ, 1'b1); // Locked NONSEQ from port 1
    @(negedge HCLK);
    check_value("grant", 32'(active_vec()), 32'h2);
    drive_port(0, 1'b1, HTRANS_NONSEQ, 1'b0);
    drive_port(2, 1'b1, HTRANS_NONSEQ, 1'b0);
    drive_port(3, 1'b1, HTRANS_NONSEQ, 1'b0);
    drive_port(1, 1'b1, HTRANS_SEQ, 1'b1);
    @(negedge HCLK);
    check_value("grant", 32'(active_vec()), 32'h2);
    drive_port(1, 1'b0, HTRANS_NONSEQ, 1'b1); // Off to another slave, still locked
    repeat (3)
    begin
      @(negedge HCLK);
      check_value("held", 32'(active_vec()), 32'h2);
      check_value("hsel", 32'(o_hsel_m), 32'h0);
      check_value("hmastlock", 32'(o_hmastlock_m), 32'h1);
    end
    drive_port(1, 1'b0, HTRANS_IDLE, 1'b0); // Lock ends
    @(negedge HCLK);
    check_value("grant", 32'(active_vec()), 32'h4);
    finish_test();

    start_test("data_phase");
    drive_port(3, 1'b0, HTRANS_IDLE, 1'b0); // Port 2 keeps its select
    @(negedge HCLK);
    check_value("active", 32'(active_vec()), 32'h1);
    check_value("hwdata", o_hwdata_m, i_hwdata[2]);
    check_value("hready", 32'(o_hreadymux_m), 32'(i_hreadyout_m));
    drive_port(2, 1'b0, HTRANS_IDLE, 1'b0);
    @(negedge HCLK);
    check_value("hwdata", o_hwdata_m, i_hwdata[0]);
    check_value("hready", 32'(o_hreadymux_m), 32'(i_hreadyout_m));
    finish_test();

    start_test("backpressure");
    i_hreadyout_m = 1'b0;                     // Slave stalls port 0
    drive_port(3, 1'b1, HTRANS_NONSEQ, 1'b0); // Port 3 waits
    repeat (4)
    begin
      @(negedge HCLK);
      check_value("hready", 32'(o_hreadymux_m), 32'h0);
      check_value("active", 32'(active_vec()), 32'h1);
      check_value("haddr", o_haddr_m, i_haddr[0]);
      check_value("hwdata", o_hwdata_m, i_hwdata[0]);
    end
    i_hreadyout_m = 1'b1;
    wait_ready();
    check_value("active", 32'(active_vec()), 32'h8);
    check_value("hwdata", o_hwdata_m, i_hwdata[0]);
    drive_port(0, 1'b0, HTRANS_IDLE, 1'b0);
    @(negedge HCLK);
    check_value("hwdata", o_hwdata_m, i_hwdata[3]);
    finish_test();

    start_test("idle_ready");
    for (int p = 0; p < `AHB_NUM_PORTS; p++)
      drive_port(p, 1'b0, HTRANS_IDLE, 1'b0);
    repeat (2) @(negedge HCLK);
    i_hreadyout_m = 1'b0; // Slave low but owns no data phase
    @(negedge HCLK);
    check_value("hready", 32'(o_hreadymux_m), 32'h1);
    check_value("active", 32'(active_vec()), 32'h0);
    i_hreadyout_m = 1'b1;
    finish_test();

    assert_fails = UUT.u_checker.fail_count;
    $display("%0d tests, %0d failed, %0d mismatches, %0d assertion failures",
             tests_run, tests_failed, errors, assert_fails);
    if (errors == 0 && assert_fails == 0)
      $display("Verification passed");
    else
      $display("Verification failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: files.f
+incdir+hdl
hdl/ahb_mtx_pkg.sv
hdl/ahb_out_arbiter.sv
hdl/ahb_addr_mux.sv
hdl/ahb_data_phase.sv
hdl/ahb_out_stage.sv
sim/ahb_out_stage_checker.sv
sim/tb_ahb_out_stage.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the AHB output stage testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  -f files.f \
  --top-module tb_ahb_out_stage \
  -o sim_tb

# Keep running past assertion errors so the testbench can report them
./obj_dir/sim_tb +verilator+error+limit+100 | tee sim.log

if grep -q "Verification passed" sim.log; then
  exit 0
fi
exit 1
